//--- build.f
+incdir+test
hw/core_pkg.sv
hw/alu.sv
hw/reg_file.sv
hw/load_store_unit.sv
hw/fetch_stage.sv
hw/decode_ctrl.sv
hw/core_top.sv
test/tb_core.sv

//--- hw/alu.sv
/*
 * ALU with a shared adder/subtractor, logic operations
 * and an equality compare for branches
 */
`timescale 1ns/1ps
`default_nettype none

module alu (
  input  core_pkg::alu_req_t        req_i,
  output logic [core_pkg::XLEN-1:0] result_o,
  output logic                      eq_o
);

  import core_pkg::*;

  logic            sub;
  logic [XLEN-1:0] b_in;
  logic [XLEN-1:0] sum;

  // Subtraction as a plus inverted b plus one
  assign sub  = (req_i.op == ALU_SUB);
  assign b_in = sub ? ~req_i.operand_b : req_i.operand_b;
  assign sum  = req_i.operand_a + b_in + XLEN'(sub);

  assign eq_o = (req_i.operand_a == req_i.operand_b);

  always_comb begin
    case (req_i.op)
      ALU_ADD,
      ALU_SUB: result_o = sum;
      ALU_AND: result_o = req_i.operand_a & req_i.operand_b;
      ALU_OR:  result_o = req_i.operand_a | req_i.operand_b;
      ALU_XOR: result_o = req_i.operand_a ^ req_i.operand_b;
      ALU_EQ:  result_o = XLEN'(eq_o);
      default: result_o = '0;
    endcase
  end

endmodule

`default_nettype wire

//--- hw/core_pkg.sv
/*
 * Shared definitions of the RV32I core: widths, major opcodes,
 * ALU operations, FSM states and the structs passed between stages
 */
`default_nettype none

package core_pkg;

  localparam int unsigned XLEN       = 32;
  localparam int unsigned REG_ADDR_W = 5;

  ////////////////////////////////////////////////////////////
  // Encodings
  ////////////////////////////////////////////////////////////

  // RV32I major opcodes handled by the decoder
  typedef enum logic [6:0] {
    OP_IMM = 7'b0010011,
    OP     = 7'b0110011,
    LUI    = 7'b0110111,
    LOAD   = 7'b0000011,
    STORE  = 7'b0100011,
    BRANCH = 7'b1100011,
    JAL    = 7'b1101111
  } opcode_e;

  typedef enum logic [2:0] {
    ALU_ADD,
    ALU_SUB,
    ALU_AND,
    ALU_OR,
    ALU_XOR,
    ALU_EQ
  } alu_op_e;

  typedef enum logic [1:0] {
    CTRL_IDLE,
    CTRL_RUN,
    CTRL_WAIT_LSU
  } ctrl_state_e;

  typedef enum logic [1:0] {
    LSU_IDLE,
    LSU_WAIT_GNT,
    LSU_WAIT_RVALID
  } lsu_state_e;

  ////////////////////////////////////////////////////////////
  // Stage structs
  ////////////////////////////////////////////////////////////

  // Instruction word with the address it was fetched from
  typedef struct packed {
    logic [XLEN-1:0] instr;
    logic [XLEN-1:0] pc;
  } fetch_item_t;

  typedef struct packed {
    logic            we;
    logic [XLEN-1:0] addr;
    logic [XLEN-1:0] wdata;
  } lsu_req_t;

  typedef struct packed {
    alu_op_e         op;
    logic [XLEN-1:0] operand_a;
    logic [XLEN-1:0] operand_b;
  } alu_req_t;

endpackage

`default_nettype wire

//--- hw/core_top.sv
/*
 * Top level of the RV32I core: fetch, decode/controller, ALU,
 * register file and load/store unit, plus the registered busy level
 */
`timescale 1ns/1ps
`default_nettype none

module core_top #(
  parameter int unsigned ExcOffset = 128
) (
  input  logic                         clk,
  input  logic                         rst_ni,
  input  logic                         fetch_enable_i,
  input  logic [core_pkg::XLEN-1:0]    boot_addr_i,
  // Instruction bus
  output logic                         instr_req_o,
  output logic [core_pkg::XLEN-1:0]    instr_addr_o,
  input  logic                         instr_gnt_i,
  input  logic                         instr_rvalid_i,
  input  logic [core_pkg::XLEN-1:0]    instr_rdata_i,
  // Data bus
  output logic                         data_req_o,
  output logic                         data_we_o,
  output logic [core_pkg::XLEN/8-1:0]  data_be_o,
  output logic [core_pkg::XLEN-1:0]    data_addr_o,
  output logic [core_pkg::XLEN-1:0]    data_wdata_o,
  input  logic                         data_gnt_i,
  input  logic                         data_rvalid_i,
  input  logic [core_pkg::XLEN-1:0]    data_rdata_i,
  output logic                         core_sleep_o
);

  import core_pkg::*;

  fetch_item_t           fetch_item;
  logic                  fetch_valid;
  logic                  fetch_en;
  logic                  accept;
  logic                  pc_set;
  logic [XLEN-1:0]       pc_target;
  logic [REG_ADDR_W-1:0] rs1_addr;
  logic [REG_ADDR_W-1:0] rs2_addr;
  logic [XLEN-1:0]       rs1_data;
  logic [XLEN-1:0]       rs2_data;
  logic                  rf_we;
  logic [REG_ADDR_W-1:0] rf_waddr;
  logic [XLEN-1:0]       rf_wdata;
  alu_req_t              alu_req;
  logic [XLEN-1:0]       alu_result;
  logic                  alu_eq;
  lsu_req_t              lsu_req;
  logic                  lsu_start;
  logic [XLEN-1:0]       lsu_rdata;
  logic                  lsu_done;
  logic                  if_busy;
  logic                  ctrl_busy;
  logic                  core_busy_q;

  // Sleep follows the busy level one cycle late
  always_ff @(posedge clk or negedge rst_ni) begin
    if (!rst_ni) begin
      core_busy_q <= 1'b0;
    end else begin
      core_busy_q <= if_busy | ctrl_busy;
    end
  end

  assign core_sleep_o = ~core_busy_q;

  fetch_stage u_fetch (
    .clk, .rst_ni, .boot_addr_i,
    .fetch_en_i    (fetch_en),
    .accept_i      (accept),
    .pc_set_i      (pc_set),
    .pc_target_i   (pc_target),
    .instr_req_o, .instr_addr_o, .instr_gnt_i, .instr_rvalid_i, .instr_rdata_i,
    .item_o        (fetch_item),
    .item_valid_o  (fetch_valid),
    .busy_o        (if_busy)
  );

  decode_ctrl #(
    .ExcOffset (ExcOffset)
  ) u_ctrl (
    .clk, .rst_ni, .fetch_enable_i, .boot_addr_i,
    .item_i        (fetch_item),
    .item_valid_i  (fetch_valid),
    .rs1_data_i    (rs1_data),
    .rs2_data_i    (rs2_data),
    .alu_result_i  (alu_result),
    .alu_eq_i      (alu_eq),
    .lsu_rdata_i   (lsu_rdata),
    .lsu_done_i    (lsu_done),
    .fetch_en_o    (fetch_en),
    .accept_o      (accept),
    .pc_set_o      (pc_set),
    .pc_target_o   (pc_target),
    .rs1_addr_o    (rs1_addr),
    .rs2_addr_o    (rs2_addr),
    .rf_we_o       (rf_we),
    .rf_waddr_o    (rf_waddr),
    .rf_wdata_o    (rf_wdata),
    .alu_req_o     (alu_req),
    .lsu_req_o     (lsu_req),
    .lsu_start_o   (lsu_start),
    .busy_o        (ctrl_busy)
  );

  alu u_alu (
    .req_i    (alu_req),
    .result_o (alu_result),
    .eq_o     (alu_eq)
  );

  reg_file u_rf (
    .clk, .rst_ni,
    .raddr_a_i (rs1_addr),
    .raddr_b_i (rs2_addr),
    .we_i      (rf_we),
    .waddr_i   (rf_waddr),
    .wdata_i   (rf_wdata),
    .rdata_a_o (rs1_data),
    .rdata_b_o (rs2_data)
  );

  load_store_unit u_lsu (
    .clk, .rst_ni,
    .req_i   (lsu_req),
    .start_i (lsu_start),
    .data_gnt_i, .data_rvalid_i, .data_rdata_i,
    .data_req_o, .data_we_o, .data_be_o, .data_addr_o, .data_wdata_o,
    .rdata_o (lsu_rdata),
    .done_o  (lsu_done)
  );

endmodule

`default_nettype wire

//--- hw/decode_ctrl.sv
/*
 * Instruction decoder and controller FSM, branch decision,
 * jump and trap targets and register write-back select
 */
`timescale 1ns/1ps
`default_nettype none

module decode_ctrl #(
  parameter int unsigned ExcOffset = 128
) (
  input  logic                            clk,
  input  logic                            rst_ni,
  input  logic                            fetch_enable_i,
  input  logic [core_pkg::XLEN-1:0]       boot_addr_i,
  input  core_pkg::fetch_item_t           item_i,
  input  logic                            item_valid_i,
  input  logic [core_pkg::XLEN-1:0]       rs1_data_i,
  input  logic [core_pkg::XLEN-1:0]       rs2_data_i,
  input  logic [core_pkg::XLEN-1:0]       alu_result_i,
  input  logic                            alu_eq_i,
  input  logic [core_pkg::XLEN-1:0]       lsu_rdata_i,
  input  logic                            lsu_done_i,
  output logic                            fetch_en_o,
  output logic                            accept_o,
  output logic                            pc_set_o,
  output logic [core_pkg::XLEN-1:0]       pc_target_o,
  output logic [core_pkg::REG_ADDR_W-1:0] rs1_addr_o,
  output logic [core_pkg::REG_ADDR_W-1:0] rs2_addr_o,
  output logic                            rf_we_o,
  output logic [core_pkg::REG_ADDR_W-1:0] rf_waddr_o,
  output logic [core_pkg::XLEN-1:0]       rf_wdata_o,
  output core_pkg::alu_req_t              alu_req_o,
  output core_pkg::lsu_req_t              lsu_req_o,
  output logic                            lsu_start_o,
  output logic                            busy_o
);

  import core_pkg::*;

  ctrl_state_e     state_q, state_d;
  logic [XLEN-1:0] instr, pc;
  opcode_e         opcode;
  logic [2:0]      funct3;
  logic [6:0]      funct7;
  logic [XLEN-1:0] imm_i, imm_s, imm_b, imm_u, imm_j;
  alu_op_e         alu_op;
  logic [XLEN-1:0] op_a, op_b;
  logic            legal, writes_rd, is_mem, is_branch, is_jal;
  logic            run_now, mem_op, taken;

  assign instr  = item_i.instr;
  assign pc     = item_i.pc;
  assign opcode = opcode_e'(instr[6:0]);
  assign funct3 = instr[14:12];
  assign funct7 = instr[31:25];

  assign imm_i = {{20{instr[31]}}, instr[31:20]};
  assign imm_s = {{20{instr[31]}}, instr[31:25], instr[11:7]};
  assign imm_b = {{19{instr[31]}}, instr[31], instr[7], instr[30:25], instr[11:8], 1'b0};
  assign imm_u = {instr[31:12], 12'b0};
  assign imm_j = {{11{instr[31]}}, instr[31], instr[19:12], instr[20], instr[30:21], 1'b0};

  ////////////////////////////////////////////////////////////
  // Decoder
  ////////////////////////////////////////////////////////////

  always_comb begin
    alu_op    = ALU_ADD;
    op_a      = rs1_data_i;
    op_b      = imm_i;
    legal     = 1'b1;
    writes_rd = 1'b0;
    is_mem    = 1'b0;
    is_branch = 1'b0;
    is_jal    = 1'b0;
    case (opcode)
      OP_IMM: begin
        // ADDI only
        legal     = (funct3 == 3'b000);
        writes_rd = 1'b1;
      end
      OP: begin
        op_b      = rs2_data_i;
        writes_rd = 1'b1;
        case ({funct7, funct3})
          {7'h00, 3'b000}: alu_op = ALU_ADD;
          {7'h20, 3'b000}: alu_op = ALU_SUB;
          {7'h00, 3'b111}: alu_op = ALU_AND;
          {7'h00, 3'b110}: alu_op = ALU_OR;
          {7'h00, 3'b100}: alu_op = ALU_XOR;
          default:         legal  = 1'b0;
        endcase
      end
      LUI: begin
        op_a      = '0;
        op_b      = imm_u;
        writes_rd = 1'b1;
      end
      LOAD: begin
        legal     = (funct3 == 3'b010);
        writes_rd = 1'b1;
        is_mem    = 1'b1;
      end
      STORE: begin
        op_b   = imm_s;
        legal  = (funct3 == 3'b010);
        is_mem = 1'b1;
      end
      BRANCH: begin
        // BEQ and BNE
        alu_op    = ALU_EQ;
        op_b      = rs2_data_i;
        legal     = (funct3[2:1] == 2'b00);
        is_branch = 1'b1;
      end
      JAL: begin
        writes_rd = 1'b1;
        is_jal    = 1'b1;
      end
      default: legal = 1'b0;
    endcase
  end

  assign taken = legal & is_branch & (funct3[0] ? ~alu_eq_i : alu_eq_i);

  ////////////////////////////////////////////////////////////
  // Controller
  ////////////////////////////////////////////////////////////

  assign run_now = (state_q == CTRL_RUN) & item_valid_i;
  assign mem_op  = is_mem & legal;

  always_comb begin
    state_d = state_q;
    case (state_q)
      CTRL_IDLE:     if (fetch_enable_i) state_d = CTRL_RUN;
      CTRL_RUN:      if (lsu_start_o) state_d = CTRL_WAIT_LSU;
      CTRL_WAIT_LSU: if (lsu_done_i) state_d = CTRL_RUN;
      default:       state_d = CTRL_IDLE;
    endcase
  end

  always_ff @(posedge clk or negedge rst_ni) begin
    if (!rst_ni) begin
      state_q <= CTRL_IDLE;
    end else begin
      state_q <= state_d;
    end
  end

  // Memory instructions stay in the slot until the LSU is done
  assign accept_o    = (run_now & ~mem_op) | ((state_q == CTRL_WAIT_LSU) & lsu_done_i);
  assign lsu_start_o = run_now & mem_op;
  assign pc_set_o    = run_now & (~legal | is_jal | taken);
  assign pc_target_o = !legal ? boot_addr_i + XLEN'(ExcOffset) :
                       is_jal ? pc + imm_j : pc + imm_b;

  assign fetch_en_o = (state_q != CTRL_IDLE);
  assign busy_o     = (state_q != CTRL_IDLE);

  // Register file and execution unit requests
  assign rs1_addr_o = instr[19:15];
  assign rs2_addr_o = instr[24:20];
  assign rf_we_o    = accept_o & legal & writes_rd;
  assign rf_waddr_o = instr[11:7];
  assign rf_wdata_o = (state_q == CTRL_WAIT_LSU) ? lsu_rdata_i :
                      is_jal ? pc + XLEN'(4) : alu_result_i;

  assign alu_req_o.op        = alu_op;
  assign alu_req_o.operand_a = op_a;
  assign alu_req_o.operand_b = op_b;

  assign lsu_req_o.we    = (opcode == STORE);
  assign lsu_req_o.addr  = alu_result_i;
  assign lsu_req_o.wdata = rs2_data_i;

  a_accept_valid: assert property (@(posedge clk) disable iff (!rst_ni)
    accept_o |-> item_valid_i);

endmodule

`default_nettype wire

//--- hw/fetch_stage.sv
/*
 * Fetch stage: fetch address, instruction bus master,
 * one prefetched instruction slot and stale response tracking
 */
`timescale 1ns/1ps
`default_nettype none

module fetch_stage (
  input  logic                      clk,
  input  logic                      rst_ni,
  input  logic [core_pkg::XLEN-1:0] boot_addr_i,
  input  logic                      fetch_en_i,
  input  logic                      accept_i,
  input  logic                      pc_set_i,
  input  logic [core_pkg::XLEN-1:0] pc_target_i,
  output logic                      instr_req_o,
  output logic [core_pkg::XLEN-1:0] instr_addr_o,
  input  logic                      instr_gnt_i,
  input  logic                      instr_rvalid_i,
  input  logic [core_pkg::XLEN-1:0] instr_rdata_i,
  output core_pkg::fetch_item_t     item_o,
  output logic                      item_valid_o,
  output logic                      busy_o
);

  import core_pkg::*;

  logic [XLEN-1:0] addr_q;
  logic            boot_sel_q;
  logic            outstanding_q;
  logic            stale_q;
  logic            slot_valid_q;
  fetch_item_t     slot_q;
  logic [XLEN-1:0] req_pc_q;
  logic            granted;
  logic            resp_ok;

  // Until the first grant or redirect the address comes from boot_addr_i
  assign instr_addr_o = boot_sel_q ? {boot_addr_i[XLEN-1:2], 2'b00} : addr_q;

  // No request during a redirect, so a waiting request never changes address
  assign instr_req_o = fetch_en_i & ~outstanding_q & ~pc_set_i &
                       (~slot_valid_q | accept_i);

  assign granted = instr_req_o & instr_gnt_i;
  assign resp_ok = instr_rvalid_i & outstanding_q & ~stale_q & ~pc_set_i;

  always_ff @(posedge clk or negedge rst_ni) begin
    if (!rst_ni) begin
      addr_q        <= '0;
      boot_sel_q    <= 1'b1;
      outstanding_q <= 1'b0;
      stale_q       <= 1'b0;
      slot_valid_q  <= 1'b0;
    end else begin
      if (pc_set_i) begin
        addr_q     <= {pc_target_i[XLEN-1:2], 2'b00};
        boot_sel_q <= 1'b0;
      end else if (granted) begin
        addr_q     <= instr_addr_o + XLEN'(4);
        boot_sel_q <= 1'b0;
      end

      if (granted) begin
        outstanding_q <= 1'b1;
      end else if (instr_rvalid_i) begin
        outstanding_q <= 1'b0;
      end

      // A response still in flight at a redirect belongs to the old path
      if (instr_rvalid_i) begin
        stale_q <= 1'b0;
      end else if (pc_set_i && outstanding_q) begin
        stale_q <= 1'b1;
      end

      if (pc_set_i) begin
        slot_valid_q <= 1'b0;
      end else if (resp_ok) begin
        slot_valid_q <= 1'b1;
      end else if (accept_i) begin
        slot_valid_q <= 1'b0;
      end
    end
  end

  always_ff @(posedge clk) begin
    if (granted) begin
      req_pc_q <= instr_addr_o;
    end
    if (resp_ok) begin
      slot_q.instr <= instr_rdata_i;
      slot_q.pc    <= req_pc_q;
    end
  end

  assign item_o       = slot_q;
  assign item_valid_o = slot_valid_q;
  assign busy_o       = instr_req_o | outstanding_q | slot_valid_q;

  a_gnt_with_req: assert property (@(posedge clk) disable iff (!rst_ni)
    instr_gnt_i |-> instr_req_o);

  a_addr_stable: assert property (@(posedge clk) disable iff (!rst_ni)
    instr_req_o && !instr_gnt_i |=> instr_req_o && $stable(instr_addr_o));

endmodule

`default_nettype wire

//--- hw/load_store_unit.sv
/*
 * Load/store unit: word accesses on the data bus,
 * load data capture and a done pulse per access
 */
`timescale 1ns/1ps
`default_nettype none

module load_store_unit (
  input  logic                        clk,
  input  logic                        rst_ni,
  input  core_pkg::lsu_req_t          req_i,
  input  logic                        start_i,
  input  logic                        data_gnt_i,
  input  logic                        data_rvalid_i,
  input  logic [core_pkg::XLEN-1:0]   data_rdata_i,
  output logic                        data_req_o,
  output logic                        data_we_o,
  output logic [core_pkg::XLEN/8-1:0] data_be_o,
  output logic [core_pkg::XLEN-1:0]   data_addr_o,
  output logic [core_pkg::XLEN-1:0]   data_wdata_o,
  output logic [core_pkg::XLEN-1:0]   rdata_o,
  output logic                        done_o
);

  import core_pkg::*;

  lsu_state_e      state_q;
  lsu_req_t        req_q;
  logic [XLEN-1:0] rdata_q;
  logic            done_q;

  always_ff @(posedge clk or negedge rst_ni) begin
    if (!rst_ni) begin
      state_q <= LSU_IDLE;
      done_q  <= 1'b0;
    end else begin
      done_q <= 1'b0;
      case (state_q)
        LSU_IDLE:        if (start_i) state_q <= LSU_WAIT_GNT;
        LSU_WAIT_GNT:    if (data_gnt_i) state_q <= LSU_WAIT_RVALID;
        LSU_WAIT_RVALID: begin
          if (data_rvalid_i) begin
            state_q <= LSU_IDLE;
            done_q  <= 1'b1;
          end
        end
        default:         state_q <= LSU_IDLE;
      endcase
    end
  end

  // Request held stable from start until grant
  always_ff @(posedge clk) begin
    if (start_i && state_q == LSU_IDLE) begin
      req_q <= req_i;
    end
    if (data_rvalid_i && state_q == LSU_WAIT_RVALID) begin
      rdata_q <= data_rdata_i;
    end
  end

  assign data_req_o   = (state_q == LSU_WAIT_GNT);
  assign data_we_o    = req_q.we;
  assign data_be_o    = '1;
  assign data_addr_o  = {req_q.addr[XLEN-1:2], 2'b00};
  assign data_wdata_o = req_q.wdata;
  assign rdata_o      = rdata_q;
  assign done_o       = done_q;

  a_start_when_idle: assert property (@(posedge clk) disable iff (!rst_ni)
    start_i |-> state_q == LSU_IDLE);

endmodule

`default_nettype wire

//--- hw/reg_file.sv
/*
 * Register file with 31 writable registers, x0 reads zero,
 * two asynchronous read ports and one write port
 */
`timescale 1ns/1ps
`default_nettype none

module reg_file (
  input  logic                            clk,
  input  logic                            rst_ni,
  input  logic [core_pkg::REG_ADDR_W-1:0] raddr_a_i,
  input  logic [core_pkg::REG_ADDR_W-1:0] raddr_b_i,
  input  logic                            we_i,
  input  logic [core_pkg::REG_ADDR_W-1:0] waddr_i,
  input  logic [core_pkg::XLEN-1:0]       wdata_i,
  output logic [core_pkg::XLEN-1:0]       rdata_a_o,
  output logic [core_pkg::XLEN-1:0]       rdata_b_o
);

  import core_pkg::*;

  logic [XLEN-1:0] regs_q [1:31];

  always_ff @(posedge clk or negedge rst_ni) begin
    if (!rst_ni) begin
      for (int i = 1; i < 32; i++) begin
        regs_q[i] <= '0;
      end
    end else if (we_i && waddr_i != '0) begin
      regs_q[waddr_i] <= wdata_i;
    end
  end

  assign rdata_a_o = (raddr_a_i == '0) ? '0 : regs_q[raddr_a_i];
  assign rdata_b_o = (raddr_b_i == '0) ? '0 : regs_q[raddr_b_i];

endmodule

`default_nettype wire

//--- test/tb_program.svh
/*
 * Test program: instruction encoders, program table,
 * preloaded data word and the table of expected stores
 */
`ifndef TB_PROGRAM_SVH
`define TB_PROGRAM_SVH

localparam logic [31:0] BOOT_ADDR  = 32'h0000_0100;
localparam logic [31:0] TRAP_ADDR  = BOOT_ADDR + 32'd128;
localparam logic [31:0] ILLEGAL_PC = BOOT_ADDR + 32'h64;
localparam logic [31:0] DATA_BASE  = 32'h0000_0400;
localparam logic [31:0] LOAD_WORD  = 32'h1234_5678;
localparam int          PROG_LEN   = 28;
localparam int          NUM_STORES = 8;

// Register values by RV32I rules
localparam logic [31:0] V1   = 32'h0000_0123;
localparam logic [31:0] V2   = 32'hABCD_E000;
localparam logic [31:0] V3   = V1 + V2;
localparam logic [31:0] V4   = V2 - V1;
localparam logic [31:0] V5   = V3 & V4;
localparam logic [31:0] V6   = V3 | V4;
localparam logic [31:0] V7   = V3 ^ V4;
localparam logic [31:0] V10  = LOAD_WORD + V1;
localparam logic [31:0] LINK = BOOT_ADDR + 32'h5C;

logic [31:0] exp_addr [NUM_STORES];
logic [31:0] exp_data [NUM_STORES];

function automatic logic [31:0] itype(input logic [11:0] imm, input logic [4:0] rs1,
                                      input logic [2:0] f3, input logic [4:0] rd,
                                      input logic [6:0] opc);
  return {imm, rs1, f3, rd, opc};
endfunction

function automatic logic [31:0] rtype(input logic [6:0] f7, input logic [4:0] rs2,
                                      input logic [4:0] rs1, input logic [2:0] f3,
                                      input logic [4:0] rd);
  return {f7, rs2, rs1, f3, rd, 7'b0110011};
endfunction

// SW only
function automatic logic [31:0] stype(input logic [11:0] imm, input logic [4:0] rs2,
                                      input logic [4:0] rs1);
  return {imm[11:5], rs2, rs1, 3'b010, imm[4:0], 7'b0100011};
endfunction

function automatic logic [31:0] btype(input logic [12:0] imm, input logic [4:0] rs2,
                                      input logic [4:0] rs1, input logic [2:0] f3);
  return {imm[12], imm[10:5], rs2, rs1, f3, imm[4:1], imm[11], 7'b1100011};
endfunction

function automatic logic [31:0] jtype(input logic [20:0] imm, input logic [4:0] rd);
  return {imm[20], imm[10:1], imm[11], imm[19:12], rd, 7'b1101111};
endfunction

task automatic place(input logic [31:0] off, input logic [31:0] word);
  imem[off[7:2]] = word;
endtask

task automatic expect_store(input int idx, input logic [31:0] off, input logic [31:0] data);
  exp_addr[idx] = DATA_BASE + off;
  exp_data[idx] = data;
endtask

task automatic load_program();
  place(32'h00, itype(12'h123, 5'd0, 3'b000, 5'd1, 7'b0010011));
  place(32'h04, {20'hABCDE, 5'd2, 7'b0110111});
  place(32'h08, rtype(7'h00, 5'd2, 5'd1, 3'b000, 5'd3));
  place(32'h0C, rtype(7'h20, 5'd1, 5'd2, 3'b000, 5'd4));
  place(32'h10, rtype(7'h00, 5'd4, 5'd3, 3'b111, 5'd5));
  place(32'h14, rtype(7'h00, 5'd4, 5'd3, 3'b110, 5'd6));
  place(32'h18, rtype(7'h00, 5'd4, 5'd3, 3'b100, 5'd7));
  place(32'h1C, itype(12'h400, 5'd0, 3'b000, 5'd8, 7'b0010011));
  place(32'h20, stype(12'd0, 5'd3, 5'd8));
  place(32'h24, stype(12'd4, 5'd4, 5'd8));
  place(32'h28, stype(12'd8, 5'd5, 5'd8));
  place(32'h2C, stype(12'd12, 5'd6, 5'd8));
  place(32'h30, stype(12'd16, 5'd7, 5'd8));
  // Load, add and store back
  place(32'h34, itype(12'd64, 5'd8, 3'b010, 5'd9, 7'b0000011));
  place(32'h38, rtype(7'h00, 5'd1, 5'd9, 3'b000, 5'd10));
  place(32'h3C, stype(12'd20, 5'd10, 5'd8));
  // Every SW at offset 60 sits on a path that must be skipped
  place(32'h40, btype(13'd8, 5'd1, 5'd1, 3'b000));
  place(32'h44, stype(12'd60, 5'd1, 5'd8));
  place(32'h48, btype(13'd8, 5'd1, 5'd1, 3'b001));
  place(32'h4C, btype(13'd8, 5'd2, 5'd1, 3'b001));
  place(32'h50, stype(12'd60, 5'd1, 5'd8));
  place(32'h54, btype(13'd8, 5'd2, 5'd1, 3'b000));
  place(32'h58, jtype(21'd8, 5'd11));
  place(32'h5C, stype(12'd60, 5'd1, 5'd8));
  place(32'h60, stype(12'd24, 5'd11, 5'd8));
  place(32'h64, 32'hFFFF_FFFF);
  // Trap handler, one store then a jump to itself
  place(32'h80, stype(12'd28, 5'd1, 5'd8));
  place(32'h84, jtype(21'd0, 5'd0));

  dmem[(DATA_BASE + 32'd64) >> 2] = LOAD_WORD;

  expect_store(0, 32'h00, V3);
  expect_store(1, 32'h04, V4);
  expect_store(2, 32'h08, V5);
  expect_store(3, 32'h0C, V6);
  expect_store(4, 32'h10, V7);
  expect_store(5, 32'h14, V10);
  expect_store(6, 32'h18, LINK);
  expect_store(7, 32'h1C, V1);
endtask

`endif

//--- test/tb_core.sv
/*
 * Testbench for the RV32I core: clock and reset, instruction and
 * data memory models with random grant delays, store checking
 */
`timescale 1ns/1ps
`default_nettype none

module tb_core;

  localparam int IMEM_WORDS = 64;
  localparam int DMEM_WORDS = 1024;

  logic [31:0] imem [IMEM_WORDS];
  logic [31:0] dmem [DMEM_WORDS];

  `include "tb_program.svh"

  localparam int TIMEOUT_CYCLES = PROG_LEN * 40 * 4;

  logic        clk;
  logic        rst_ni;
  logic        fetch_enable_i;
  logic [31:0] boot_addr_i;
  logic        instr_req_o;
  logic [31:0] instr_addr_o;
  logic        instr_gnt_i;
  logic        instr_rvalid_i;
  logic [31:0] instr_rdata_i;
  logic        data_req_o;
  logic        data_we_o;
  logic [3:0]  data_be_o;
  logic [31:0] data_addr_o;
  logic [31:0] data_wdata_o;
  logic        data_gnt_i;
  logic        data_rvalid_i;
  logic [31:0] data_rdata_i;
  logic        core_sleep_o;

  integer      seed = 32'h5e74;
  int          errors;
  int          cycle_cnt;
  int          st_cnt;
  int          ld_cnt;
  int          iwait;
  int          dwait;
  logic [31:0] igrant_addr;
  logic        igrant_seen;
  logic        trap_pending;
  logic [31:0] dgrant_rdata;
  logic [31:0] st_addr [NUM_STORES];
  logic [31:0] st_data [NUM_STORES];

  core_top #(
    .ExcOffset (128)
  ) dut (
    .clk, .rst_ni, .fetch_enable_i, .boot_addr_i,
    .instr_req_o, .instr_addr_o, .instr_gnt_i, .instr_rvalid_i, .instr_rdata_i,
    .data_req_o, .data_we_o, .data_be_o, .data_addr_o, .data_wdata_o,
    .data_gnt_i, .data_rvalid_i, .data_rdata_i,
    .core_sleep_o
  );

  always #20 clk = ~clk;

  always @(posedge clk) cycle_cnt++;

  ////////////////////////////////////////////////////////////
  // Helpers
  ////////////////////////////////////////////////////////////

  task automatic check_value(input string name, input logic [31:0] got,
                             input logic [31:0] exp);
    if (got !== exp) begin
      errors++;
      $display("[FAIL] %s: got 0x%08h, expected 0x%08h", name, got, exp);
    end
  endtask

  function automatic int draw_latency();
    return $unsigned($random(seed)) % 3;
  endfunction

  // Illegal opcode 7'h7f in every word outside the program
  function automatic logic [31:0] instr_fill(input logic [31:0] addr);
    return {addr[31:7] ^ addr[24:0], 7'h7F};
  endfunction

  function automatic logic [31:0] data_fill(input logic [31:0] addr);
    return addr ^ 32'hA5A5_5A5A;
  endfunction

  function automatic logic [31:0] imem_word(input logic [31:0] addr);
    logic [31:0] off;
    off = addr - BOOT_ADDR;
    if (off < IMEM_WORDS * 4) begin
      return imem[off[7:2]];
    end else begin
      return instr_fill(addr);
    end
  endfunction

  task automatic note_fetch(input logic [31:0] addr);
    if (!igrant_seen) begin
      check_value("first instr_addr_o", addr, BOOT_ADDR);
      igrant_seen = 1'b1;
    end
    if (trap_pending) begin
      check_value("instr_addr_o after illegal", addr, TRAP_ADDR);
      trap_pending = 1'b0;
    end
    if (addr == ILLEGAL_PC) trap_pending = 1'b1;
  endtask

  ////////////////////////////////////////////////////////////
  // Bus models, rvalid one cycle after the grant
  ////////////////////////////////////////////////////////////

  task automatic serve_instr_bus();
    instr_rvalid_i = 1'b0;
    if (instr_gnt_i) begin
      instr_rvalid_i = 1'b1;
      instr_rdata_i  = imem_word(igrant_addr);
    end
    instr_gnt_i = 1'b0;
    if (!instr_req_o) begin
      iwait = -1;
    end else begin
      if (iwait < 0) iwait = draw_latency();
      if (iwait == 0) begin
        instr_gnt_i = 1'b1;
        igrant_addr = instr_addr_o;
        iwait       = -1;
        note_fetch(instr_addr_o);
      end else begin
        iwait--;
      end
    end
  endtask

  task automatic access_data_mem();
    check_value("data_be_o", {28'h0, data_be_o}, 32'hF);
    if (data_addr_o >= DMEM_WORDS * 4) begin
      errors++;
      $display("Data access outside the memory at address 0x%08h", data_addr_o);
    end else if (data_we_o) begin
      dmem[data_addr_o[11:2]] = data_wdata_o;
      if (st_cnt < NUM_STORES) begin
        st_addr[st_cnt] = data_addr_o;
        st_data[st_cnt] = data_wdata_o;
      end else begin
        errors++;
        $display("Unexpected extra store to address 0x%08h", data_addr_o);
      end
      st_cnt++;
    end else begin
      check_value("load data_addr_o", data_addr_o, DATA_BASE + 32'd64);
      dgrant_rdata = dmem[data_addr_o[11:2]];
      ld_cnt++;
    end
  endtask

  task automatic serve_data_bus();
    data_rvalid_i = 1'b0;
    if (data_gnt_i) begin
      data_rvalid_i = 1'b1;
      data_rdata_i  = dgrant_rdata;
    end
    data_gnt_i = 1'b0;
    if (!data_req_o) begin
      dwait = -1;
    end else begin
      if (dwait < 0) dwait = draw_latency();
      if (dwait == 0) begin
        data_gnt_i = 1'b1;
        dwait      = -1;
        access_data_mem();
      end else begin
        dwait--;
      end
    end
  endtask

  always begin
    @(posedge clk);
    #2;
    serve_instr_bus();
    serve_data_bus();
  end

  ////////////////////////////////////////////////////////////
  // Main sequence
  ////////////////////////////////////////////////////////////

  initial begin
    clk            = 1'b0;
    rst_ni         = 1'b0;
    fetch_enable_i = 1'b0;
    boot_addr_i    = BOOT_ADDR;
    instr_gnt_i    = 1'b0;
    instr_rvalid_i = 1'b0;
    instr_rdata_i  = '0;
    data_gnt_i     = 1'b0;
    data_rvalid_i  = 1'b0;
    data_rdata_i   = '0;
    errors         = 0;
    cycle_cnt      = 0;
    st_cnt         = 0;
    ld_cnt         = 0;
    iwait          = -1;
    dwait          = -1;
    igrant_seen    = 1'b0;
    trap_pending   = 1'b0;
    dgrant_rdata   = '0;
    for (int i = 0; i < IMEM_WORDS; i++) begin
      imem[i] = instr_fill(BOOT_ADDR + i * 4);
    end
    for (int i = 0; i < DMEM_WORDS; i++) begin
      dmem[i] = data_fill(i * 4);
    end
    load_program();

    repeat (5) @(posedge clk);
    #2;
    rst_ni = 1'b1;

    // Idle and asleep until fetch_enable_i
    repeat (8) begin
      @(posedge clk);
      #2;
      check_value("instr_req_o", instr_req_o, 1'b0);
      check_value("data_req_o", data_req_o, 1'b0);
      check_value("core_sleep_o", core_sleep_o, 1'b1);
    end
    fetch_enable_i = 1'b1;

    // Controller leaves idle here, sleep drops one cycle later
    @(posedge clk);
    #2;
    check_value("instr_req_o", instr_req_o, 1'b1);
    check_value("instr_addr_o", instr_addr_o, BOOT_ADDR);
    check_value("core_sleep_o", core_sleep_o, 1'b1);
    @(posedge clk);
    #2;
    check_value("core_sleep_o", core_sleep_o, 1'b0);

    while (st_cnt < NUM_STORES && cycle_cnt < TIMEOUT_CYCLES) begin
      @(posedge clk);
    end
    if (st_cnt < NUM_STORES) begin
      errors++;
      $display("Timeout after %0d cycles with %0d of %0d stores seen",
               cycle_cnt, st_cnt, NUM_STORES);
    end else begin
      // Quiet period to catch stray data requests
      repeat (50) @(posedge clk);
    end

    for (int i = 0; i < NUM_STORES; i++) begin
      if (i < st_cnt) begin
        check_value($sformatf("store %0d data_addr_o", i), st_addr[i], exp_addr[i]);
        check_value($sformatf("store %0d data_wdata_o", i), st_data[i], exp_data[i]);
      end
    end
    check_value("store count", st_cnt, NUM_STORES);
    check_value("load count", ld_cnt, 1);

    $display("Errors: %0d, stores: %0d of %0d, loads: %0d, cycles: %0d",
             errors, st_cnt, NUM_STORES, ld_cnt, cycle_cnt);
    if (errors == 0) begin
      $display("Simulation PASSED");
    end else begin
      $display("Simulation FAILED");
    end
    $finish;
  end

endmodule

`default_nettype wire
